//--- common/tally_pkg.sv
`default_nettype none

package tally_pkg;

    // one vote per core per round
    // only -1, 0 and +1 are ever produced
    typedef logic signed [1:0] vote_t;

    localparam vote_t vote_pos  = 2'sb01;
    localparam vote_t vote_neg  = 2'sb11;
    localparam vote_t vote_none = 2'sb00;

    // host bus geometry
    localparam int wb_data_width = 32;
    // word address, four registers
    localparam int wb_addr_width = 2;

    // register map, word offsets

    // write only, written word carries the per-core results
    localparam logic [wb_addr_width-1:0] reg_round = 2'd0;

    // read/write participation mask, bit k enables core k
    localparam logic [wb_addr_width-1:0] reg_mask = 2'd1;

    // read only, accumulator sign-extended to the bus width
    localparam logic [wb_addr_width-1:0] reg_sum = 2'd2;

    // read gives busy in bit 0 and sign in bit 1
    // write with bit 0 set clears the accumulator
    localparam logic [wb_addr_width-1:0] reg_status = 2'd3;

    // status bit positions
    localparam int status_busy_bit  = 0;
    localparam int status_sign_bit  = 1;
    localparam int status_clear_bit = 0;

endpackage

`default_nettype wire

//--- vote_counter/vote_selector.sv
`timescale 1ns/1ns
`default_nettype none

module vote_selector
    import tally_pkg::*;
(
    input  logic  clk,
    // core stored a result this cycle
    input  logic  store_bit,
    // the result bit itself
    input  logic  core_result_bit,
    // registered vote for this core
    output vote_t sel_bit
);

    vote_t vote_next;

    // +1 for a high result, -1 for a low one
    // no store means no vote
    always_comb begin
        if (store_bit) begin
            if (core_result_bit) begin
                vote_next = vote_pos;
            end else begin
                vote_next = vote_neg;
            end
        end else begin
            vote_next = vote_none;
        end
    end

    // first pipeline stage
    // only summed under the delayed store flag
    always_ff @(posedge clk) begin
        sel_bit <= vote_next;
    end

endmodule

`default_nettype wire

//--- vote_counter/vote_counter.sv
`timescale 1ns/1ns
`default_nettype none

module vote_counter
    import tally_pkg::*;
#(
    // number of cores reporting, 1 to 32
    parameter int core_count = 16,
    // accumulator width, up to the bus width
    parameter int acc_width  = 30
) (
    input  logic                        clk,
    input  logic                        rst,
    // one-cycle accumulator clear
    input  logic                        clear,
    // per-core store strobes
    input  logic [core_count-1:0]       store,
    // per-core result bits
    input  logic [core_count-1:0]       core_result,
    // running signed tally
    output logic signed [acc_width-1:0] sum,
    // some round still in the pipeline
    output logic                        busy,
    // decision, high when the tally is negative
    output logic                        sign_bit
);

    // round total must hold -core_count .. +core_count
    localparam int total_width = $clog2(core_count + 1) + 1;

    // stage 1, one vote per core
    vote_t votes [core_count];

    // round tracking flags, matched to the data stages
    logic store_any;
    logic store_d1;
    logic store_d2;

    // stage 2, all votes of one round added up
    logic signed [total_width-1:0] vote_sum;
    logic signed [total_width-1:0] round_total;

    // stage 3, the running tally
    logic signed [acc_width-1:0] acc;
    logic signed [acc_width-1:0] acc_base;
    logic signed [acc_width-1:0] acc_add;

    // one selector per core
    for (genvar k = 0; k < core_count; k++) begin : g_sel
        vote_selector u_sel (
            .clk             (clk),
            .store_bit       (store[k]),
            .core_result_bit (core_result[k]),
            .sel_bit         (votes[k])
        );
    end

    // any core storing starts a round
    // cores need not store together
    assign store_any = |store;

    // flag follows the votes through the adder stage
    always_ff @(posedge clk) begin
        if (rst) begin
            store_d1 <= 1'b0;
            store_d2 <= 1'b0;
        end else begin
            store_d1 <= store_any;
            store_d2 <= store_d1;
        end
    end

    // adder tree over all votes
    // each vote sign-extended before the add
    always_comb begin
        vote_sum = '0;
        for (int k = 0; k < core_count; k++) begin
            vote_sum = vote_sum + total_width'(votes[k]);
        end
    end

    // round total register
    // consumed only while store_d2 is set
    always_ff @(posedge clk) begin
        round_total <= vote_sum;
    end

    // clear drops the old tally
    // a round landing on the same edge survives the clear
    assign acc_base = clear ? '0 : acc;
    assign acc_add  = store_d2 ? acc_width'(round_total) : '0;

    // separate adder and accumulator stages
    // so back-to-back rounds are all taken
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (clear || store_d2) begin
            acc <= acc_base + acc_add;
        end
    end

    assign sum = acc;

    // top bit gives the decision
    assign sign_bit = acc[acc_width-1];

    // low again once the last round is in the tally
    assign busy = store_any | store_d1 | store_d2;

endmodule

`default_nettype wire

//--- hdl/wb_tally_regs.sv
`timescale 1ns/1ns
`default_nettype none

module wb_tally_regs
    import tally_pkg::*;
#(
    // number of cores, sets mask and result width
    parameter int core_count = 16,
    // width of the tally read back
    parameter int acc_width  = 30
) (
    input  logic                        clk,
    input  logic                        rst,

    // wishbone classic slave
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [wb_addr_width-1:0]    wb_adr,
    input  logic [wb_data_width-1:0]    wb_dat_w,
    output logic [wb_data_width-1:0]    wb_dat_r,
    output logic                        wb_ack,

    // from the counter
    input  logic signed [acc_width-1:0] sum,
    input  logic                        busy,
    input  logic                        sign_bit,

    // to the counter
    output logic [core_count-1:0]       store,
    output logic [core_count-1:0]       core_result,
    output logic                        clear
);

    // participation mask
    logic [core_count-1:0] mask;

    // transaction decode
    logic accept;
    logic wr_round;
    logic wr_mask;
    logic wr_clear;

    // read data before the output register
    logic [wb_data_width-1:0] rd_word;

    // new request, ack not yet given
    // ack low for a cycle between transactions
    assign accept = wb_cyc && wb_stb && !wb_ack;

    assign wr_round = accept && wb_we && (wb_adr == reg_round);
    assign wr_mask  = accept && wb_we && (wb_adr == reg_mask);
    assign wr_clear = accept && wb_we && (wb_adr == reg_status)
                      && wb_dat_w[status_clear_bit];

    // single-cycle ack on the edge after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    // all cores take part after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mask <= '1;
        end else if (wr_mask) begin
            mask <= wb_dat_w[core_count-1:0];
        end
    end

    // round and clear pulses
    // both line up with the ack cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            store <= '0;
            clear <= 1'b0;
        end else begin
            // masked cores see no store at all
            store <= wr_round ? mask : '0;
            clear <= wr_clear;
        end
    end

    // result word, upper bits beyond core_count dropped
    always_ff @(posedge clk) begin
        if (wr_round) begin
            core_result <= wb_dat_w[core_count-1:0];
        end
    end

    // readback mux
    always_comb begin
        case (wb_adr)
            reg_mask: begin
                // zero-extended
                rd_word = wb_data_width'(mask);
            end
            reg_sum: begin
                // signed source, so this sign-extends
                rd_word = wb_data_width'(sum);
            end
            reg_status: begin
                rd_word = '0;
                rd_word[status_busy_bit] = busy;
                rd_word[status_sign_bit] = sign_bit;
            end
            default: begin
                // round register reads as zero
                rd_word = '0;
            end
        endcase
    end

    // read data captured with the ack
    // valid only while wb_ack is high
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tally_top.sv
`timescale 1ns/1ns
`default_nettype none

module tally_top
    import tally_pkg::*;
#(
    // cores in the array, 1 to 32
    parameter int core_count = 16,
    // tally width, at most the bus width
    parameter int acc_width  = 30
) (
    input  logic                     clk,
    input  logic                     rst,

    // host bus
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [wb_data_width-1:0] wb_dat_w,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic                     wb_ack,

    // decision, for direct use outside the bus
    output logic                     sign_bit
);

    // register block to counter
    logic [core_count-1:0] store;
    logic [core_count-1:0] core_result;
    logic                  clear;

    // counter back to register block
    logic signed [acc_width-1:0] sum;
    logic                        busy;

    // host side, stands in for the core array
    wb_tally_regs #(
        .core_count (core_count),
        .acc_width  (acc_width)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .sum         (sum),
        .busy        (busy),
        .sign_bit    (sign_bit),
        .store       (store),
        .core_result (core_result),
        .clear       (clear)
    );

    // three-stage vote pipeline
    vote_counter #(
        .core_count (core_count),
        .acc_width  (acc_width)
    ) u_counter (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .store       (store),
        .core_result (core_result),
        .sum         (sum),
        .busy        (busy),
        .sign_bit    (sign_bit)
    );

endmodule

`default_nettype wire

//--- bench/tally_tb_tasks.svh
`ifndef TALLY_TB_TASKS_SVH
`define TALLY_TB_TASKS_SVH

    // to the next drive point after the rising edge
    task automatic step();
        @(posedge clk);
        #drive_delay;
    endtask

    // +1 per taking-part core with a high result, -1 with a low one
    function automatic int round_delta(input logic [core_count-1:0] mask,
                                       input logic [core_count-1:0] word);
        int delta;
        delta = 0;
        for (int k = 0; k < core_count; k++) begin
            if (mask[k]) begin
                delta = word[k] ? delta + 1 : delta - 1;
            end
        end
        return delta;
    endfunction

    task automatic wb_write(input logic [wb_addr_width-1:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = addr;
        wb_dat_w = data;
        strobe_cycle = cycle;
        step();
        while (!wb_ack && waited < ack_timeout) begin
            step();
            waited++;
        end
        if (!wb_ack) begin
            stop_on_timeout("no wishbone ack on a write");
        end else begin
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we = 1'b0;
            // bus idle for a cycle, next strobe is seen fresh
            step();
        end
    endtask

    task automatic wb_read(input logic [wb_addr_width-1:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = addr;
        strobe_cycle = cycle;
        step();
        while (!wb_ack && waited < ack_timeout) begin
            step();
            waited++;
        end
        data = wb_dat_r;
        if (!wb_ack) begin
            stop_on_timeout("no wishbone ack on a read");
        end else begin
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            // bus idle for a cycle, next strobe is seen fresh
            step();
        end
    endtask

    // status reads until the pipeline is empty
    task automatic wait_idle();
        logic [31:0] status;
        int polls;
        polls = 0;
        wb_read(reg_status, status);
        while (status[0] && polls < busy_timeout) begin
            wb_read(reg_status, status);
            polls++;
        end
        if (status[0]) begin
            stop_on_timeout("busy flag never went low");
        end
    endtask

    task automatic load_mask(input logic [core_count-1:0] mask);
        cur_mask = mask;
        wb_write(reg_mask, 32'(mask));
    endtask

    // model first, then fire the round
    task automatic run_round(input logic [core_count-1:0] word);
        model_sum = model_sum + round_delta(cur_mask, word);
        wb_write(reg_round, 32'(word));
    endtask

    task automatic check_sum();
        logic [31:0] rd;
        wb_read(reg_sum, rd);
        check_value("reg_sum", 32'(model_sum), rd);
    endtask

`endif

//--- bench/tally_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tally_tb
    import tally_pkg::*;
();

    localparam int core_count   = 16;
    localparam int acc_width    = 30;
    localparam int clk_period   = 40;
    // inputs move this long after the rising edge
    localparam int drive_delay  = 5;
    // cycles to wait for an ack
    localparam int ack_timeout  = 16;
    // status reads before giving up on busy
    localparam int busy_timeout = 32;

    logic                     clk;
    logic                     rst;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic                     wb_ack;
    logic                     sign_bit;

    // free-running cycle count, for the latency test
    int cycle;
    // cycle in which the last strobe went up
    int strobe_cycle;
    int pass_count;
    int fail_count;
    int test_fail_start;
    string test_name;
    int seed;
    // expected tally
    int model_sum;
    logic [core_count-1:0] cur_mask;

    tally_top #(
        .core_count (core_count),
        .acc_width  (acc_width)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sign_bit (sign_bit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ack is a single-cycle pulse, low again right after
    ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            $display("wb_ack stayed high for more than one cycle");
            fail_count++;
        end

    // a fresh strobe gets its ack on the next edge
    ack_follows_strobe: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_cyc && wb_stb) |=> wb_ack)
        else begin
            $display("strobe was not acknowledged on the next edge");
            fail_count++;
        end

    store_pulse: assert property (@(posedge clk) disable iff (rst)
        (|u_dut.store) |=> !(|u_dut.store))
        else begin
            $display("store pulse lasted more than one cycle");
            fail_count++;
        end

    clear_pulse: assert property (@(posedge clk) disable iff (rst)
        u_dut.clear |=> !u_dut.clear)
        else begin
            $display("clear pulse lasted more than one cycle");
            fail_count++;
        end

    // pipeline drains within three cycles of the last round
    busy_drains: assert property (@(posedge clk) disable iff (rst)
        (|u_dut.store) ##1 (!(|u_dut.store)) [*3] |-> !u_dut.busy)
        else begin
            $display("busy still high three cycles after the last store");
            fail_count++;
        end

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

`include "tally_tb_tasks.svh"

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) begin
            pass_count++;
        end else begin
            $display("error: %s expected 0x%h, got 0x%h", name, expected, actual);
            fail_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_fail_start = fail_count;
    endtask

    task automatic end_test();
        $display("test %s: %s", test_name, (fail_count == test_fail_start) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] rd;
        int old_sum;
        seed = 78;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        model_sum = 0;
        cur_mask = '1;
        repeat (8) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        step();

        begin_test("reset state");
        check_value("sign_bit", 32'h0, 32'(sign_bit));
        wb_read(reg_sum, rd);
        check_value("reg_sum", 32'h0, rd);
        wb_read(reg_status, rd);
        check_value("reg_status", 32'h0, rd);
        wb_read(reg_mask, rd);
        check_value("reg_mask", 32'h0000ffff, rd);
        end_test();

        // full mask, +16, back to 0, then -16
        begin_test("full mask rounds");
        run_round(16'hffff);
        wait_idle();
        wb_read(reg_sum, rd);
        check_value("reg_sum", 32'h10, rd);
        run_round(16'h0000);
        wait_idle();
        wb_read(reg_sum, rd);
        check_value("reg_sum", 32'h0, rd);
        run_round(16'h0000);
        wait_idle();
        wb_read(reg_sum, rd);
        check_value("reg_sum", 32'hfffffff0, rd);
        check_value("sign_bit", 32'h1, 32'(sign_bit));
        wb_read(reg_status, rd);
        check_value("reg_status", 32'h2, rd);
        end_test();

        begin_test("mask handling");
        load_mask(core_count'($random(seed)));
        repeat (4) begin
            run_round(core_count'($random(seed)));
            wait_idle();
            check_sum();
        end
        // no core takes part, tally must hold
        old_sum = model_sum;
        load_mask('0);
        run_round(core_count'($random(seed)));
        wait_idle();
        wb_read(reg_sum, rd);
        check_value("reg_sum", 32'(old_sum), rd);
        end_test();

        // no polling between rounds
        begin_test("back-to-back rounds");
        load_mask(core_count'($random(seed)));
        repeat (20) begin
            run_round(core_count'($random(seed)));
        end
        wait_idle();
        check_sum();
        check_value("sign_bit", 32'(model_sum < 0), 32'(sign_bit));
        end_test();

        begin_test("clear and sign extension");
        wb_write(reg_status, 32'h1);
        model_sum = 0;
        wait_idle();
        check_sum();
        check_value("sign_bit", 32'h0, 32'(sign_bit));
        load_mask('1);
        run_round(16'h0000);
        run_round(16'h0000);
        wait_idle();
        wb_read(reg_sum, rd);
        check_value("reg_sum", 32'hffffffe0, rd);
        end_test();

        // old tally through strobe+3, new one at strobe+4
        begin_test("round latency");
        old_sum = model_sum;
        run_round(16'h0fff);
        while (cycle < strobe_cycle + 3) begin
            step();
        end
        check_value("sum", 32'(old_sum), 32'(u_dut.sum));
        step();
        check_value("sum", 32'(model_sum), 32'(u_dut.sum));
        check_value("sign_bit", 32'(model_sum < 0), 32'(sign_bit));
        end_test();

        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/tally_pkg.sv
vote_counter/vote_selector.sv
vote_counter/vote_counter.sv
hdl/wb_tally_regs.sv
hdl/tally_top.sv
+incdir+bench
bench/tally_tb.sv
